// ==== source/l2_config.svh ====
`ifndef L2_CONFIG_SVH
`define L2_CONFIG_SVH

// ------------------------------
// cache geometry
// ------------------------------
`define L2_WAYS       4   // associativity
`define L2_SETS       16
`define L2_SET_BITS   4   // log2 of L2_SETS

// ------------------------------
// widths
// ------------------------------
`define L2_ADDR_BITS  16  // line address, not byte address
`define L2_LINE_BITS  64
`define L2_AGE_BITS   2   // enough to rank L2_WAYS ways

`endif

// ==== source/l2_pkg.sv ====
`include "l2_config.svh"

package l2_pkg;

    // plain vectors with a meaning of their own
    typedef logic [`L2_ADDR_BITS-1:0]              line_addr_t;
    typedef logic [`L2_SET_BITS-1:0]               set_idx_t;   // low bits of a line address
    typedef logic [`L2_ADDR_BITS-`L2_SET_BITS-1:0] tag_t;       // upper bits of a line address
    typedef logic [$clog2(`L2_WAYS)-1:0]           way_idx_t;
    typedef logic [`L2_AGE_BITS-1:0]               lru_age_t;   // 0 is least recent
    typedef logic [`L2_LINE_BITS-1:0]              cache_line_t;

    // per line bookkeeping
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } meta_t;

    // one access from the requester
    typedef struct packed {
        logic        write;
        line_addr_t  addr;
        cache_line_t wdata;   // ignored on reads
    } core_req_t;

    // writeback to memory
    typedef struct packed {
        line_addr_t  addr;
        cache_line_t data;
    } mem_wr_t;

endpackage

// ==== source/l2_way_store.sv ====
`timescale 1ns/1ps
`include "l2_config.svh"

module l2_way_store
    import l2_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  set_idx_t    read_set,
    input  logic        write_en,
    input  set_idx_t    write_set,
    input  meta_t       write_meta,
    input  cache_line_t write_line,
    output meta_t       read_meta,
    output cache_line_t read_line
);

    logic [`L2_SETS-1:0] valid_bits;   // cleared on reset
    logic [`L2_SETS-1:0] dirty_bits;
    tag_t                tag_mem  [`L2_SETS];
    cache_line_t         line_mem [`L2_SETS];

    // ------------------------------
    // state bits
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (write_en) begin
            valid_bits[write_set] <= write_meta.valid;
            dirty_bits[write_set] <= write_meta.dirty;
        end
    end

    // tag and data arrays
    always_ff @(posedge clock) begin
        if (write_en) begin
            tag_mem[write_set]  <= write_meta.tag;
            line_mem[write_set] <= write_line;
        end
    end

    // registered read, old contents on a same-edge write
    always_ff @(posedge clock) begin
        read_meta.valid <= valid_bits[read_set];
        read_meta.dirty <= dirty_bits[read_set];
        read_meta.tag   <= tag_mem[read_set];
        read_line       <= line_mem[read_set];
    end

endmodule

// ==== source/l2_lru.sv ====
`timescale 1ns/1ps
`include "l2_config.svh"

module l2_lru
    import l2_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  set_idx_t lookup_set,
    output way_idx_t victim_way,
    input  logic     touch,
    input  set_idx_t touch_set,
    input  way_idx_t touch_way
);

    // one age per way per set, ages in a set are a permutation
    lru_age_t [`L2_SETS-1:0][`L2_WAYS-1:0] ages;
    lru_age_t                              touched_age;

    assign touched_age = ages[touch_set][touch_way];

    // ------------------------------
    // victim is the age 0 way
    // ------------------------------
    always_comb begin
        victim_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (ages[lookup_set][w] == '0) begin
                victim_way = way_idx_t'(w);
            end
        end
    end

    // ------------------------------
    // age update
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            // way number as age, so empty ways go first in order
            for (int s = 0; s < `L2_SETS; s++) begin
                for (int w = 0; w < `L2_WAYS; w++) begin
                    ages[s][w] <= lru_age_t'(w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                if (way_idx_t'(w) == touch_way) begin
                    ages[touch_set][w] <= lru_age_t'(`L2_WAYS - 1);   // most recent
                end else if (ages[touch_set][w] > touched_age) begin
                    ages[touch_set][w] <= ages[touch_set][w] - 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/l2_controller.sv ====
`timescale 1ns/1ps
`include "l2_config.svh"

module l2_controller
    import l2_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    // requester side
    input  core_req_t                  core_req,
    input  logic                       core_req_valid,
    output logic                       core_ack,
    output cache_line_t                core_rdata,
    // way stores
    output set_idx_t                   read_set,
    input  meta_t       [`L2_WAYS-1:0] way_meta,
    input  cache_line_t [`L2_WAYS-1:0] way_line,
    output logic        [`L2_WAYS-1:0] way_write_en,
    output set_idx_t                   write_set,
    output meta_t                      write_meta,
    output cache_line_t                write_line,
    // replacement
    input  way_idx_t                   victim_way,
    output logic                       touch,
    output set_idx_t                   touch_set,
    output way_idx_t                   touch_way,
    // memory read channel
    output logic                       mem_rd_req,
    output line_addr_t                 mem_rd_addr,
    input  logic                       mem_rd_ack,
    input  cache_line_t                mem_rd_data,
    // memory write channel
    output logic                       mem_wr_req,
    output mem_wr_t                    mem_wr,
    input  logic                       mem_wr_ack
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_WB_RELEASE,
        ST_REFILL,
        ST_REFILL_RELEASE,
        ST_RESPOND
    } state_t;

    state_t      state, state_next;
    core_req_t   req_q;         // latched access
    way_idx_t    victim_q;
    cache_line_t fill_line_q;   // refill data from memory
    set_idx_t    req_set;
    tag_t        req_tag;
    logic        hit;
    way_idx_t    hit_way;
    logic        finish;        // access done, go respond
    logic        install;       // write the target way
    way_idx_t    target_way;
    cache_line_t result_line;

    assign req_set = req_q.addr[`L2_SET_BITS-1:0];
    assign req_tag = req_q.addr[`L2_ADDR_BITS-1:`L2_SET_BITS];

    // index from the live request while idle, so lookup data is ready next cycle
    assign read_set = (state == ST_IDLE) ? core_req.addr[`L2_SET_BITS-1:0] : req_set;

    // ------------------------------
    // tag compare
    // ------------------------------
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (way_meta[w].valid && (way_meta[w].tag == req_tag)) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    // ------------------------------
    // next state and strobes
    // ------------------------------
    always_comb begin
        state_next  = state;
        finish      = 1'b0;
        install     = 1'b0;
        target_way  = victim_q;
        result_line = fill_line_q;
        case (state)
            ST_IDLE: begin
                if (core_req_valid) state_next = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                if (hit) begin
                    finish      = 1'b1;
                    install     = req_q.write;   // a read hit only touches
                    target_way  = hit_way;
                    result_line = req_q.write ? req_q.wdata : way_line[hit_way];
                end else if (way_meta[victim_way].valid && way_meta[victim_way].dirty) begin
                    state_next = ST_WRITEBACK;
                end else if (req_q.write) begin
                    finish      = 1'b1;          // write miss needs no fetch
                    install     = 1'b1;
                    target_way  = victim_way;
                    result_line = req_q.wdata;
                end else begin
                    state_next = ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (mem_wr_ack) state_next = ST_WB_RELEASE;
            end
            ST_WB_RELEASE: begin
                if (!mem_wr_ack) begin
                    if (req_q.write) begin
                        finish      = 1'b1;
                        install     = 1'b1;
                        result_line = req_q.wdata;
                    end else begin
                        state_next = ST_REFILL;
                    end
                end
            end
            ST_REFILL: begin
                if (mem_rd_ack) state_next = ST_REFILL_RELEASE;
            end
            ST_REFILL_RELEASE: begin
                if (!mem_rd_ack) begin
                    finish  = 1'b1;
                    install = 1'b1;
                end
            end
            ST_RESPOND: begin
                if (!core_req_valid) state_next = ST_IDLE;   // hold ack until req drops
            end
            default: state_next = ST_IDLE;
        endcase
        if (finish) state_next = ST_RESPOND;
    end

    // array and LRU updates
    assign way_write_en = install ? (`L2_WAYS'(1) << target_way) : '0;
    assign write_set    = req_set;
    assign write_meta   = '{valid: 1'b1, dirty: req_q.write, tag: req_tag};
    assign write_line   = result_line;
    assign touch        = finish;
    assign touch_set    = req_set;
    assign touch_way    = target_way;

    // memory channels follow the state
    assign mem_rd_req  = (state == ST_REFILL);
    assign mem_rd_addr = req_q.addr;
    assign mem_wr_req  = (state == ST_WRITEBACK);

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= ST_IDLE;
            core_ack <= 1'b0;
        end else begin
            state    <= state_next;
            core_ack <= (state_next == ST_RESPOND);
        end
    end

    always_ff @(posedge clock) begin
        if ((state == ST_IDLE) && core_req_valid) req_q <= core_req;
        if (state == ST_LOOKUP) begin
            victim_q    <= victim_way;
            mem_wr.addr <= {way_meta[victim_way].tag, req_set};   // victim line address
            mem_wr.data <= way_line[victim_way];
        end
        if ((state == ST_REFILL) && mem_rd_ack) fill_line_q <= mem_rd_data;
        if (finish) core_rdata <= result_line;
    end

endmodule

// ==== source/l2_cache.sv ====
`timescale 1ns/1ps
`include "l2_config.svh"

module l2_cache
    import l2_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  core_req_t   core_req,
    input  logic        core_req_valid,
    output logic        core_ack,
    output cache_line_t core_rdata,
    output logic        mem_rd_req,
    output line_addr_t  mem_rd_addr,
    input  logic        mem_rd_ack,
    input  cache_line_t mem_rd_data,
    output logic        mem_wr_req,
    output mem_wr_t     mem_wr,
    input  logic        mem_wr_ack
);

    set_idx_t                   read_set;
    meta_t       [`L2_WAYS-1:0] way_meta;
    cache_line_t [`L2_WAYS-1:0] way_line;
    logic        [`L2_WAYS-1:0] way_write_en;
    set_idx_t                   write_set;
    meta_t                      write_meta;
    cache_line_t                write_line;
    way_idx_t                   victim_way;
    logic                       touch;
    set_idx_t                   touch_set;
    way_idx_t                   touch_way;

    // ------------------------------
    // one store per way
    // ------------------------------
    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        l2_way_store i_way_store (
            .clock      (clock),
            .reset      (reset),
            .read_set   (read_set),
            .write_en   (way_write_en[w]),
            .write_set  (write_set),
            .write_meta (write_meta),
            .write_line (write_line),
            .read_meta  (way_meta[w]),
            .read_line  (way_line[w])
        );
    end

    l2_lru i_lru (
        .clock      (clock),
        .reset      (reset),
        .lookup_set (read_set),   // same set the ways are reading
        .victim_way (victim_way),
        .touch      (touch),
        .touch_set  (touch_set),
        .touch_way  (touch_way)
    );

    l2_controller i_controller (
        .clock          (clock),
        .reset          (reset),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_ack       (core_ack),
        .core_rdata     (core_rdata),
        .read_set       (read_set),
        .way_meta       (way_meta),
        .way_line       (way_line),
        .way_write_en   (way_write_en),
        .write_set      (write_set),
        .write_meta     (write_meta),
        .write_line     (write_line),
        .victim_way     (victim_way),
        .touch          (touch),
        .touch_set      (touch_set),
        .touch_way      (touch_way),
        .mem_rd_req     (mem_rd_req),
        .mem_rd_addr    (mem_rd_addr),
        .mem_rd_ack     (mem_rd_ack),
        .mem_rd_data    (mem_rd_data),
        .mem_wr_req     (mem_wr_req),
        .mem_wr         (mem_wr),
        .mem_wr_ack     (mem_wr_ack)
    );

endmodule

// ==== testbench/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model
    import l2_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        mem_rd_req,
    input  line_addr_t  mem_rd_addr,
    output logic        mem_rd_ack,
    output cache_line_t mem_rd_data,
    input  logic        mem_wr_req,
    input  mem_wr_t     mem_wr,
    output logic        mem_wr_ack
);

    cache_line_t lines [line_addr_t];   // only lines written back so far
    logic [31:0] lcg_state = 32'd68310;
    int unsigned rd_wait;
    int unsigned wr_wait;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // 0 to 3 cycles before an ack
    function automatic int unsigned ack_delay();
        return (next_random() >> 16) % 4;
    endfunction

    function automatic cache_line_t stored_line(line_addr_t addr);
        if (lines.exists(addr)) return lines[addr];
        return {4{addr}};   // untouched line holds its own address
    endfunction

    initial begin
        mem_rd_ack  = 1'b0;
        mem_rd_data = '0;
        mem_wr_ack  = 1'b0;
    end

    // ------------------------------
    // both channels, driven on the falling edge
    // ------------------------------
    always @(negedge clock) begin
        if (reset) begin
            mem_rd_ack <= 1'b0;
            mem_wr_ack <= 1'b0;
            rd_wait    <= ack_delay();
            wr_wait    <= ack_delay();
        end else begin
            if (mem_rd_req && !mem_rd_ack) begin
                if (rd_wait == 0) begin
                    mem_rd_ack  <= 1'b1;
                    mem_rd_data <= stored_line(mem_rd_addr);
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end else if (!mem_rd_req && mem_rd_ack) begin
                mem_rd_ack <= 1'b0;
                rd_wait    <= ack_delay();
            end
            if (mem_wr_req && !mem_wr_ack) begin
                if (wr_wait == 0) begin
                    mem_wr_ack          <= 1'b1;
                    lines[mem_wr.addr]   = mem_wr.data;   // commit with the ack
                end else begin
                    wr_wait <= wr_wait - 1;
                end
            end else if (!mem_wr_req && mem_wr_ack) begin
                mem_wr_ack <= 1'b0;
                wr_wait    <= ack_delay();
            end
        end
    end

endmodule

// ==== testbench/tb_l2_cache.sv ====
`timescale 1ns/1ps

module tb_l2_cache
    import l2_pkg::*;
();

    localparam int directed_requests = 13;
    localparam int random_requests   = 300;
    localparam int cycle_limit       = (directed_requests + random_requests) * 40 + 200;

    logic        clock = 1'b0;
    logic        reset;
    core_req_t   core_req;
    logic        core_req_valid;
    logic        core_ack;
    cache_line_t core_rdata;
    logic        mem_rd_req;
    line_addr_t  mem_rd_addr;
    logic        mem_rd_ack;
    cache_line_t mem_rd_data;
    logic        mem_wr_req;
    mem_wr_t     mem_wr;
    logic        mem_wr_ack;

    cache_line_t shadow [line_addr_t];   // latest written line per address
    logic [31:0] lcg_state = 32'd68310;
    line_addr_t  conflict [5] = '{16'h0107, 16'h0117, 16'h0127, 16'h0137, 16'h0147};
    int          touch_order [4] = '{2, 0, 3, 1};   // leaves conflict[2] least recent
    int          mismatches = 0;
    int          protocol_errors = 0;
    int          request_count = 0;
    int          ack_count = 0;
    int          rd_count = 0;
    int          wb_count = 0;
    int          cycle_count = 0;
    line_addr_t  last_rd_addr;
    line_addr_t  last_wb_addr;
    logic        first_request_sent = 1'b0;
    logic        ack_prev = 1'b0;
    logic        valid_prev = 1'b0;
    logic        rd_req_prev = 1'b0;
    logic        rd_ack_prev = 1'b0;
    logic        wr_req_prev = 1'b0;
    logic        wr_ack_prev = 1'b0;

    always #4 clock = ~clock;

    l2_cache i_l2_cache (.*);

    tb_mem_model i_mem_model (.*);

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic cache_line_t expected_line(line_addr_t addr);
        if (shadow.exists(addr)) return shadow[addr];
        return {4{addr}};
    endfunction

    // one four-phase access, entered and left on a falling edge
    task automatic run_access(input logic write, input line_addr_t addr,
                              input cache_line_t wdata, output cache_line_t rdata);
        core_req.write     = write;
        core_req.addr      = addr;
        core_req.wdata     = wdata;
        core_req_valid     = 1'b1;
        first_request_sent = 1'b1;
        request_count++;
        if (write) shadow[addr] = wdata;
        while (!core_ack) @(negedge clock);
        rdata          = core_rdata;
        core_req_valid = 1'b0;
        while (core_ack) @(negedge clock);
    endtask

    task automatic read_and_check(input line_addr_t addr);
        cache_line_t rdata;
        run_access(1'b0, addr, '0, rdata);
        assert (rdata == expected_line(addr)) else begin
            mismatches++;
            $display("mismatch at %0t: read %h returned %h, expected %h",
                     $time, addr, rdata, expected_line(addr));
        end
    endtask

    task automatic write_data(input line_addr_t addr, input cache_line_t wdata);
        cache_line_t rdata;
        run_access(1'b1, addr, wdata, rdata);
    endtask

    // ------------------------------
    // bus monitor
    // ------------------------------
    always @(posedge clock) begin
        if (!reset) begin
            if (!first_request_sent) begin
                assert (!core_ack && !mem_rd_req && !mem_wr_req) else begin
                    protocol_errors++;
                    $display("handshake output high before any request at %0t", $time);
                end
            end
            if (core_ack && !ack_prev) begin
                ack_count++;
                assert (valid_prev) else begin   // decided on the req seen at the last edge
                    protocol_errors++;
                    $display("core_ack rose without a request at %0t", $time);
                end
            end
            if (rd_req_prev && !rd_ack_prev) begin
                assert (mem_rd_req) else begin
                    protocol_errors++;
                    $display("memory read req dropped before its ack at %0t", $time);
                end
            end
            if (wr_req_prev && !wr_ack_prev) begin
                assert (mem_wr_req) else begin
                    protocol_errors++;
                    $display("memory write req dropped before its ack at %0t", $time);
                end
            end
            if (mem_rd_req && mem_rd_ack) begin
                rd_count++;
                last_rd_addr = mem_rd_addr;
            end
            if (mem_wr_req && mem_wr_ack) begin
                wb_count++;
                last_wb_addr = mem_wr.addr;
                assert (mem_wr.data == expected_line(mem_wr.addr)) else begin
                    mismatches++;
                    $display("mismatch at %0t: writeback of %h carried %h, expected %h",
                             $time, mem_wr.addr, mem_wr.data, expected_line(mem_wr.addr));
                end
            end
        end
        ack_prev    = core_ack;
        valid_prev  = core_req_valid;
        rd_req_prev = mem_rd_req;
        rd_ack_prev = mem_rd_ack;
        wr_req_prev = mem_wr_req;
        wr_ack_prev = mem_wr_ack;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        line_addr_t  addr;
        int          reads_before;
        int          wbs_before;
        reset          = 1'b1;
        core_req       = '0;
        core_req_valid = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (3) @(negedge clock);   // quiet cycles for the idle check

        // cold read goes to memory
        reads_before = rd_count;
        read_and_check(16'h0121);
        assert (rd_count == reads_before + 1 && last_rd_addr == 16'h0121) else begin
            protocol_errors++;
            $display("cold read miss made no memory read of 0121 at %0t", $time);
        end

        // write then read hits without memory
        write_data(16'h0341, 64'h0123_4567_89ab_cdef);
        reads_before = rd_count;
        read_and_check(16'h0341);
        assert (rd_count == reads_before) else begin
            protocol_errors++;
            $display("read after write went to memory at %0t", $time);
        end

        // ------------------------------
        // LRU eviction in set 7
        // ------------------------------
        for (int i = 0; i < 4; i++) write_data(conflict[i], {next_random(), next_random()});
        for (int i = 0; i < 4; i++) read_and_check(conflict[touch_order[i]]);
        wbs_before = wb_count;
        write_data(conflict[4], {next_random(), next_random()});
        assert (wb_count == wbs_before + 1 && last_wb_addr == conflict[2]) else begin
            mismatches++;
            $display("mismatch at %0t: writeback address %h, expected %h",
                     $time, last_wb_addr, conflict[2]);
        end
        read_and_check(conflict[2]);   // refetch after the eviction

        // random traffic over sets 12 to 15, 16 tags each
        for (int n = 0; n < random_requests; n++) begin
            r    = next_random();
            addr = {8'h00, r[23:20], 2'b11, r[17:16]};
            if (r[28]) write_data(addr, {next_random(), next_random()});
            else read_and_check(addr);
        end

        assert (ack_count == request_count) else begin
            protocol_errors++;
            $display("core_ack rose %0d times for %0d requests", ack_count, request_count);
        end
        $display("%0d requests, %0d mismatches, %0d protocol errors",
                 request_count, mismatches, protocol_errors);
        if (mismatches == 0 && protocol_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+source
source/l2_pkg.sv
source/l2_way_store.sv
source/l2_lru.sv
source/l2_controller.sv
source/l2_cache.sv
testbench/tb_mem_model.sv
testbench/tb_l2_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then search the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module tb_l2_cache -f sim.f --Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
